/* Makefile */
# Verilator build and run for the memory subsystem testbench.
# Every variable can be overridden on the command line.

VERILATOR  ?= verilator
TOP        ?= mem_controller_tb
RTL_TOP    ?= mem_controller
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= >>> PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint lint-rtl clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

lint-rtl:
	$(VERILATOR) $(LINT_FLAGS) design/mem_map_pkg.sv design/mem_port_pkg.sv \
		design/mem_bank.sv design/mem_bank_arbiter.sv design/mem_controller.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/mem_bank.sv */
/*
 * Single-port synchronous RAM with a byte write mask.
 * Read data is registered and shows the old word during a write.
 * Contents are undefined after power-up, there is no init file.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_bank
#(
	parameter int WORD_BITS = 14
)
(
	input  logic                              CLK,
	input  logic [WORD_BITS-1:0]              addr,
	input  logic [mem_map_pkg::DATA_BITS-1:0] wdata,
	output logic [mem_map_pkg::DATA_BITS-1:0] rdata,
	input  logic [mem_map_pkg::MASK_BITS-1:0] mask,
	input  logic                              wr
);

	logic [mem_map_pkg::DATA_BITS-1:0] mem [2**WORD_BITS];

	always_ff @(posedge CLK)
	begin
		rdata <= mem[addr]; // read before write
		if (wr)
		begin
			for (int i = 0; i < mem_map_pkg::MASK_BITS; i++)
			begin
				if (mask[i])
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8]; // one byte lane
			end
		end
	end

endmodule

`default_nettype wire

/* design/mem_bank_arbiter.sv */
/*
 * Per-bank fixed priority arbiter: sprite, background, CPU, flash.
 * A winner in cycle N gets ready or success in cycle N+1.
 * Requesters hold valid until ready. A steady sprite stream
 * starves lower requesters on that bank, there is no fairness.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_bank_arbiter
(
	input  logic CLK,
	input  logic arst_n,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] sprite_addr,
	output logic [mem_map_pkg::DATA_BITS-1:0] sprite_data,
	input  logic                              sprite_rvalid,
	output logic                              sprite_rready,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] bg0_addr,
	output logic [mem_map_pkg::DATA_BITS-1:0] bg0_data,
	input  logic                              bg0_rvalid,
	output logic                              bg0_rready,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] fl_addr,
	input  logic [mem_map_pkg::DATA_BITS-1:0] fl_data,
	input  logic                              fl_wvalid,
	output logic                              fl_wready,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] cpu_addr,
	input  logic [mem_map_pkg::DATA_BITS-1:0] cpu_wdata,
	output logic [mem_map_pkg::DATA_BITS-1:0] cpu_rdata,
	input  logic                              cpu_wr,
	input  logic [mem_map_pkg::MASK_BITS-1:0] cpu_wr_mask,
	input  logic                              cpu_valid,
	output logic                              cpu_success,

	output logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::BANK_WORD_BITS-1:0] bank_addr,
	output logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::DATA_BITS-1:0]      bank_wdata,
	input  logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::DATA_BITS-1:0]      bank_rdata,
	output logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::MASK_BITS-1:0]      bank_mask,
	output logic [mem_map_pkg::BANK_COUNT-1:0]                                  bank_wr
);

	mem_port_pkg::requester_e win_d [mem_map_pkg::BANK_COUNT]; // grant this cycle
	mem_port_pkg::requester_e win_q [mem_map_pkg::BANK_COUNT]; // grant of last cycle

	logic [mem_port_pkg::NUM_REQUESTERS-1:0] req;  // bit 0 sprite up to bit 3 flash
	logic [mem_port_pkg::NUM_REQUESTERS-1:0] busy; // requester is in its ready cycle

	logic [mem_map_pkg::BANK_SEL_BITS-1:0] sprite_sel;
	logic [mem_map_pkg::BANK_SEL_BITS-1:0] bg0_sel;
	logic [mem_map_pkg::BANK_SEL_BITS-1:0] cpu_sel;
	logic [mem_map_pkg::BANK_SEL_BITS-1:0] fl_sel;

	assign sprite_sel = sprite_addr[mem_map_pkg::ADDR_BITS-1 -: mem_map_pkg::BANK_SEL_BITS];
	assign bg0_sel    = bg0_addr[mem_map_pkg::ADDR_BITS-1 -: mem_map_pkg::BANK_SEL_BITS];
	assign cpu_sel    = cpu_addr[mem_map_pkg::ADDR_BITS-1 -: mem_map_pkg::BANK_SEL_BITS];
	assign fl_sel     = fl_addr[mem_map_pkg::ADDR_BITS-1 -: mem_map_pkg::BANK_SEL_BITS];

	// valid is still held while ready is high, so that cycle must not win again
	assign req = {fl_wvalid, cpu_valid, bg0_rvalid, sprite_rvalid} & ~busy;

	always_comb
	begin
		for (int b = 0; b < mem_map_pkg::BANK_COUNT; b++)
		begin
			win_d[b]      = mem_port_pkg::req_none;
			bank_addr[b]  = '0;
			bank_wdata[b] = '0;
			bank_mask[b]  = '0;
			bank_wr[b]    = 1'b0;
			if (req[0] && sprite_sel == mem_map_pkg::BANK_SEL_BITS'(b))
			begin
				win_d[b]     = mem_port_pkg::req_sprite;
				bank_addr[b] = sprite_addr[mem_map_pkg::BANK_WORD_BITS-1:0];
			end
			else if (req[1] && bg0_sel == mem_map_pkg::BANK_SEL_BITS'(b))
			begin
				win_d[b]     = mem_port_pkg::req_bg0;
				bank_addr[b] = bg0_addr[mem_map_pkg::BANK_WORD_BITS-1:0];
			end
			else if (req[2] && cpu_sel == mem_map_pkg::BANK_SEL_BITS'(b))
			begin
				win_d[b]      = mem_port_pkg::req_cpu;
				bank_addr[b]  = cpu_addr[mem_map_pkg::BANK_WORD_BITS-1:0];
				bank_wdata[b] = cpu_wdata;
				bank_mask[b]  = cpu_wr_mask;
				bank_wr[b]    = cpu_wr;
			end
			else if (req[3] && fl_sel == mem_map_pkg::BANK_SEL_BITS'(b))
			begin
				win_d[b]      = mem_port_pkg::req_flash;
				bank_addr[b]  = fl_addr[mem_map_pkg::BANK_WORD_BITS-1:0];
				bank_wdata[b] = fl_data;
				bank_mask[b]  = '1; // flash always writes whole words
				bank_wr[b]    = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int b = 0; b < mem_map_pkg::BANK_COUNT; b++)
				win_q[b] <= mem_port_pkg::req_none;
		end
		else
		begin
			for (int b = 0; b < mem_map_pkg::BANK_COUNT; b++)
				win_q[b] <= win_d[b];
		end
	end

	// a requester holds one address, so at most one bank returns to it
	always_comb
	begin
		busy        = '0;
		sprite_data = '0;
		bg0_data    = '0;
		cpu_rdata   = '0;
		for (int b = 0; b < mem_map_pkg::BANK_COUNT; b++)
		begin
			case (win_q[b])
				mem_port_pkg::req_sprite:
				begin
					busy[0]     = 1'b1;
					sprite_data = bank_rdata[b];
				end
				mem_port_pkg::req_bg0:
				begin
					busy[1]  = 1'b1;
					bg0_data = bank_rdata[b];
				end
				mem_port_pkg::req_cpu:
				begin
					busy[2]   = 1'b1;
					cpu_rdata = bank_rdata[b];
				end
				mem_port_pkg::req_flash:
					busy[3] = 1'b1; // write done, nothing to return
				default:
					;
			endcase
		end
	end

	assign sprite_rready = busy[0];
	assign bg0_rready    = busy[1];
	assign cpu_success   = busy[2];
	assign fl_wready     = busy[3];

endmodule

`default_nettype wire

/* design/mem_controller.sv */
/*
 * Memory subsystem top: four 16K word banks, one arbiter and a
 * 256 word boot memory over CPU page 0x00. Only the CPU sees the
 * boot memory, and boot accesses always finish in one cycle.
 * Banks and boot memory power up undefined.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_controller
(
	input  logic CLK,
	input  logic arst_n,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] sprite_addr,
	output logic [mem_map_pkg::DATA_BITS-1:0] sprite_data,
	input  logic                              sprite_rvalid,
	output logic                              sprite_rready,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] bg0_addr,
	output logic [mem_map_pkg::DATA_BITS-1:0] bg0_data,
	input  logic                              bg0_rvalid,
	output logic                              bg0_rready,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] fl_addr,
	input  logic [mem_map_pkg::DATA_BITS-1:0] fl_data,
	input  logic                              fl_wvalid,
	output logic                              fl_wready,

	input  logic [mem_map_pkg::ADDR_BITS-1:0] cpu_addr,
	input  logic [mem_map_pkg::DATA_BITS-1:0] cpu_wdata,
	output logic [mem_map_pkg::DATA_BITS-1:0] cpu_rdata,
	input  logic                              cpu_wr,
	input  logic [mem_map_pkg::MASK_BITS-1:0] cpu_wr_mask,
	input  logic                              cpu_valid,
	output logic                              cpu_success
);

	logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::BANK_WORD_BITS-1:0] bank_addr;
	logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::DATA_BITS-1:0]      bank_wdata;
	logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::DATA_BITS-1:0]      bank_rdata;
	logic [mem_map_pkg::BANK_COUNT-1:0][mem_map_pkg::MASK_BITS-1:0]      bank_mask;
	logic [mem_map_pkg::BANK_COUNT-1:0]                                  bank_wr;

	logic [mem_map_pkg::DATA_BITS-1:0] boot_rdata;
	logic [mem_map_pkg::DATA_BITS-1:0] arb_rdata;
	logic arb_success;
	logic boot_page;      // CPU address lies in the overlay
	logic boot_go;        // boot access taken this cycle
	logic boot_hit_q;     // last CPU access went to boot memory
	logic boot_success_q;

	assign boot_page = cpu_addr[mem_map_pkg::ADDR_BITS-1:mem_map_pkg::BOOT_WORD_BITS]
		== mem_map_pkg::BOOT_PAGE;
	assign boot_go = cpu_valid && boot_page && !boot_success_q; // not again in the done cycle

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			boot_hit_q     <= 1'b0;
			boot_success_q <= 1'b0;
		end
		else
		begin
			if (cpu_valid)
				boot_hit_q <= boot_page;
			boot_success_q <= boot_go;
		end
	end

	assign cpu_rdata   = boot_hit_q ? boot_rdata : arb_rdata;
	assign cpu_success = boot_success_q | arb_success;

	mem_bank #(.WORD_BITS(mem_map_pkg::BANK_WORD_BITS)) bank_0 (.CLK(CLK), .addr(bank_addr[0]),
		.wdata(bank_wdata[0]), .rdata(bank_rdata[0]), .mask(bank_mask[0]), .wr(bank_wr[0]));
	mem_bank #(.WORD_BITS(mem_map_pkg::BANK_WORD_BITS)) bank_1 (.CLK(CLK), .addr(bank_addr[1]),
		.wdata(bank_wdata[1]), .rdata(bank_rdata[1]), .mask(bank_mask[1]), .wr(bank_wr[1]));
	mem_bank #(.WORD_BITS(mem_map_pkg::BANK_WORD_BITS)) bank_2 (.CLK(CLK), .addr(bank_addr[2]),
		.wdata(bank_wdata[2]), .rdata(bank_rdata[2]), .mask(bank_mask[2]), .wr(bank_wr[2]));
	mem_bank #(.WORD_BITS(mem_map_pkg::BANK_WORD_BITS)) bank_3 (.CLK(CLK), .addr(bank_addr[3]),
		.wdata(bank_wdata[3]), .rdata(bank_rdata[3]), .mask(bank_mask[3]), .wr(bank_wr[3]));

	mem_bank #(.WORD_BITS(mem_map_pkg::BOOT_WORD_BITS)) boot_mem (.CLK(CLK),
		.addr(cpu_addr[mem_map_pkg::BOOT_WORD_BITS-1:0]), .wdata(cpu_wdata),
		.rdata(boot_rdata), .mask(cpu_wr_mask), .wr(boot_go && cpu_wr));

	mem_bank_arbiter arb (
		.CLK(CLK), .arst_n(arst_n),
		.sprite_addr(sprite_addr), .sprite_data(sprite_data),
		.sprite_rvalid(sprite_rvalid), .sprite_rready(sprite_rready),
		.bg0_addr(bg0_addr), .bg0_data(bg0_data),
		.bg0_rvalid(bg0_rvalid), .bg0_rready(bg0_rready),
		.fl_addr(fl_addr), .fl_data(fl_data), .fl_wvalid(fl_wvalid), .fl_wready(fl_wready),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_rdata(arb_rdata),
		.cpu_wr(cpu_wr), .cpu_wr_mask(cpu_wr_mask),
		.cpu_valid(cpu_valid && !boot_page), // boot page never reaches the banks
		.cpu_success(arb_success),
		.bank_addr(bank_addr), .bank_wdata(bank_wdata), .bank_rdata(bank_rdata),
		.bank_mask(bank_mask), .bank_wr(bank_wr)
	);

endmodule

`default_nettype wire

/* design/mem_map_pkg.sv */
/*
 * Address map and word format of the memory subsystem.
 * Four banks of 16K words, selected by address bits 15 and 14.
 * The boot memory overlays CPU page 0x00 only.
 * Mask bit 0 enables the low byte and bit 1 the high byte.
 */
`default_nettype none

package mem_map_pkg;

	localparam int DATA_BITS      = 16; // one word
	localparam int ADDR_BITS      = 16; // requester address
	localparam int BANK_SEL_BITS  = 2;  // top address bits
	localparam int BANK_COUNT     = 4;
	localparam int BANK_WORD_BITS = 14; // word index inside a bank

	localparam logic [7:0] BOOT_PAGE = 8'h00; // high address byte of the overlay
	localparam int BOOT_WORD_BITS    = 8;

	localparam int MASK_BITS = 2; // byte enables

endpackage

`default_nettype wire

/* design/mem_port_pkg.sv */
/*
 * Requester identities as seen by the bank arbiter.
 * Priority on a shared bank follows the enum order after req_none.
 */
`default_nettype none

package mem_port_pkg;

	localparam int NUM_REQUESTERS = 4;

	typedef enum logic [2:0] {
		req_none,
		req_sprite,
		req_bg0,
		req_cpu,
		req_flash
	} requester_e;

endpackage

`default_nettype wire

/* dv/mem_controller_properties.sv */
/*
 * Concurrent checks on the memory subsystem ports, bound to the top level.
 * Ready bits are ordered sprite, background, CPU, flash.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_controller_properties
(
	input wire logic CLK,
	input wire logic arst_n,
	input wire logic sprite_rvalid,
	input wire logic sprite_rready,
	input wire logic bg0_rvalid,
	input wire logic bg0_rready,
	input wire logic fl_wvalid,
	input wire logic fl_wready,
	input wire logic cpu_valid,
	input wire logic cpu_success,
	input wire logic [mem_map_pkg::ADDR_BITS-1:0] cpu_addr
);

	logic [mem_port_pkg::NUM_REQUESTERS-1:0] ready_vec;
	logic [mem_port_pkg::NUM_REQUESTERS-1:0] valid_vec;
	logic boot_req;

	assign ready_vec = {fl_wready, cpu_success, bg0_rready, sprite_rready};
	assign valid_vec = {fl_wvalid, cpu_valid, bg0_rvalid, sprite_rvalid};
	assign boot_req  = cpu_valid && cpu_addr[15:8] == mem_map_pkg::BOOT_PAGE;

	ready_after_valid: assert property (@(posedge CLK) disable iff (!arst_n)
		(ready_vec & ~$past(valid_vec)) == '0)
		else $error("ready without valid in the cycle before");

	quiet_in_reset: assert property (@(posedge CLK) !arst_n |-> ready_vec == '0)
		else $error("ready or success high during reset");

	boot_one_cycle: assert property (@(posedge CLK) disable iff (!arst_n)
		boot_req && !cpu_success |=> cpu_success)
		else $error("boot access not done in one cycle");

endmodule

bind mem_controller mem_controller_properties props (
	.CLK(CLK), .arst_n(arst_n),
	.sprite_rvalid(sprite_rvalid), .sprite_rready(sprite_rready),
	.bg0_rvalid(bg0_rvalid), .bg0_rready(bg0_rready),
	.fl_wvalid(fl_wvalid), .fl_wready(fl_wready),
	.cpu_valid(cpu_valid), .cpu_success(cpu_success), .cpu_addr(cpu_addr)
);

`default_nettype wire

/* dv/mem_controller_tb.sv */
/*
 * Testbench for the memory subsystem top level.
 * Shadow arrays model the banks and the boot memory; requester tasks
 * queue expected words and the compare process checks every ready.
 * Every read address is written before it is read.
 * Random traffic uses a 32 bit Galois LFSR seeded 32'h3078edfe.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_controller_tb;

	localparam int TIMEOUT = 50;                   // cycles per wait
	localparam logic [31:0] LFSR_POLY = 32'h80200003;

	logic CLK;
	logic arst_n;
	logic [mem_map_pkg::ADDR_BITS-1:0] sprite_addr, bg0_addr, fl_addr, cpu_addr;
	logic [mem_map_pkg::DATA_BITS-1:0] sprite_data, bg0_data, fl_data, cpu_wdata, cpu_rdata;
	logic sprite_rvalid, sprite_rready, bg0_rvalid, bg0_rready, fl_wvalid, fl_wready;
	logic cpu_wr, cpu_valid, cpu_success;
	logic [mem_map_pkg::MASK_BITS-1:0] cpu_wr_mask;

	logic [15:0] shadow [65536];   // all four banks by full address
	logic [15:0] boot_shadow [256];
	logic [15:0] sprite_exp [$];
	logic [15:0] bg0_exp [$];
	logic [15:0] cpu_exp [$];
	bit cpu_is_read [$];
	int order [$];                 // completion order from 0 sprite up to 3 flash
	int mismatches, timeouts, strays;
	int fl_pending;                // flash writes still waiting for wready
	logic [31:0] lfsr;

	mem_controller dut (.*);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] data,
		input logic [1:0] mask);
		logic [15:0] r;
		r = old;
		if (mask[0])
			r[7:0] = data[7:0];
		if (mask[1])
			r[15:8] = data[15:8];
		return r;
	endfunction

	// only the CPU sees boot memory on page 0x00
	function automatic logic [15:0] ref_read(input logic [15:0] addr, input bit cpu_view);
		if (cpu_view && addr[15:8] == 8'h00)
			return boot_shadow[addr[7:0]];
		return shadow[addr];
	endfunction

	function automatic logic ready_of(input int p);
		case (p)
			0: return sprite_rready;
			1: return bg0_rready;
			2: return cpu_success;
			default: return fl_wready;
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic stray_ready(input string who);
		strays++;
		$display("%s raised ready at %0t with no request pending", who, $time);
	endtask

	task automatic wait_done(input int p, output int lat);
		lat = 0;
		do
		begin
			@(negedge CLK);
			lat++;
		end while (!ready_of(p) && lat < TIMEOUT);
		if (!ready_of(p))
		begin
			timeouts++;
			$display("requester %0d got no ready within %0d cycles", p, TIMEOUT);
		end
	endtask

	task automatic sprite_read(input logic [15:0] addr, output int lat);
		sprite_exp.push_back(ref_read(addr, 1'b0));
		sprite_addr = addr;
		sprite_rvalid = 1'b1;
		wait_done(0, lat);
		sprite_rvalid = 1'b0;
		@(negedge CLK); // idle cycle between requests
	endtask

	task automatic bg0_read(input logic [15:0] addr, output int lat);
		bg0_exp.push_back(ref_read(addr, 1'b0));
		bg0_addr = addr;
		bg0_rvalid = 1'b1;
		wait_done(1, lat);
		bg0_rvalid = 1'b0;
		@(negedge CLK);
	endtask

	task automatic cpu_access(input logic [15:0] addr, input logic wr, input logic [15:0] data,
		input logic [1:0] mask, output int lat);
		cpu_is_read.push_back(!wr);
		cpu_exp.push_back(ref_read(addr, 1'b1));
		if (wr && addr[15:8] == 8'h00)
			boot_shadow[addr[7:0]] = merge_bytes(boot_shadow[addr[7:0]], data, mask);
		else if (wr)
			shadow[addr] = merge_bytes(shadow[addr], data, mask);
		cpu_addr = addr;
		cpu_wr = wr;
		cpu_wdata = data;
		cpu_wr_mask = mask;
		cpu_valid = 1'b1;
		wait_done(2, lat);
		cpu_valid = 1'b0;
		@(negedge CLK);
	endtask

	task automatic flash_write(input logic [15:0] addr, input logic [15:0] data, output int lat);
		shadow[addr] = data; // flash always writes the full word
		fl_pending++;
		fl_addr = addr;
		fl_data = data;
		fl_wvalid = 1'b1;
		wait_done(3, lat);
		fl_wvalid = 1'b0;
		@(negedge CLK);
	endtask

	always @(negedge CLK)
	begin : compare
		logic [15:0] cpu_word;
		if (sprite_rready)
		begin
			order.push_back(0);
			if (sprite_exp.size() == 0)
				stray_ready("sprite");
			else
				check("sprite read data", 32'(sprite_data), 32'(sprite_exp.pop_front()));
		end
		if (bg0_rready)
		begin
			order.push_back(1);
			if (bg0_exp.size() == 0)
				stray_ready("background");
			else
				check("background read data", 32'(bg0_data), 32'(bg0_exp.pop_front()));
		end
		if (cpu_success)
		begin
			order.push_back(2);
			if (cpu_exp.size() == 0)
				stray_ready("cpu");
			else
			begin
				cpu_word = cpu_exp.pop_front();
				if (cpu_is_read.pop_front())
					check("cpu read data", 32'(cpu_rdata), 32'(cpu_word));
			end
		end
		if (fl_wready)
		begin
			order.push_back(3);
			if (fl_pending == 0)
				stray_ready("flash");
			else
				fl_pending--;
		end
	end

	initial
	begin
		int lat_s, lat_b, lat_c, lat_f;
		logic [15:0] a;
		logic [15:0] ra [4];
		logic [15:0] rd [2];
		logic en [4];
		logic cw;
		logic [1:0] cm;
		logic [1:0] bank;
		logic [3:0] word;

		lfsr = 32'h3078edfe;
		mismatches = 0;
		timeouts = 0;
		strays = 0;
		fl_pending = 0;
		arst_n = 1'b0;
		{sprite_addr, bg0_addr, fl_addr, cpu_addr, fl_data, cpu_wdata} = '0;
		{sprite_rvalid, bg0_rvalid, fl_wvalid, cpu_wr, cpu_valid} = '0;
		cpu_wr_mask = '0;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		arst_n = 1'b1;
		@(negedge CLK);

		// every CPU mask on all banks with read back
		for (int b = 0; b < 4; b++)
		begin
			a = {2'(b), 14'h0123};
			cpu_access(a, 1'b1, 16'h5aa5, 2'b11, lat_c);
			check("cpu write latency", lat_c, 1);
			for (int m = 0; m < 4; m++)
			begin
				cpu_access(a, 1'b1, {2'(b), 2'(m), 12'h3c9}, 2'(m), lat_c);
				cpu_access(a, 1'b0, 16'h0000, 2'b00, lat_c);
				check("cpu read latency", lat_c, 1);
			end
		end

		// flash writes read back by the display engines
		for (int b = 0; b < 4; b++)
		begin
			a = {2'(b), 14'h0200} + 16'(b);
			flash_write(a, a ^ 16'h96e1, lat_f);
			check("flash latency", lat_f, 1);
			sprite_read(a, lat_s);
			check("sprite latency", lat_s, 1);
			bg0_read(a, lat_b);
			check("background latency", lat_b, 1);
		end

		// fill and read back every boot word
		for (int i = 0; i < 256; i++)
		begin
			cpu_access({8'h00, 8'(i)}, 1'b1, {8'(i) ^ 8'ha5, 8'(i)}, 2'b11, lat_c);
			check("boot write latency", lat_c, 1);
		end
		for (int i = 0; i < 256; i++)
		begin
			cpu_access({8'h00, 8'(i)}, 1'b0, 16'h0000, 2'b00, lat_c);
			check("boot read latency", lat_c, 1);
		end
		flash_write(16'h0000, 16'hbeef, lat_f);
		cpu_access(16'h0000, 1'b0, 16'h0000, 2'b00, lat_c); // returns the boot word
		sprite_read(16'h0000, lat_s);                       // bank 0 word

		// four requesters on bank 2 in one cycle
		flash_write(16'h8010, 16'h1357, lat_f);
		flash_write(16'h8011, 16'h2468, lat_f);
		order.delete();
		fork
			sprite_read(16'h8010, lat_s);
			bg0_read(16'h8011, lat_b);
			cpu_access(16'h8012, 1'b1, 16'h1234, 2'b11, lat_c);
			flash_write(16'h8013, 16'h4321, lat_f);
		join
		check("contention completions", order.size(), 4);
		for (int i = 0; i < order.size(); i++)
			check("completion order", order[i], i);
		check("sprite contention latency", lat_s, 1);
		check("background contention latency", lat_b, 2);
		check("cpu contention latency", lat_c, 3);
		check("flash contention latency", lat_f, 4);
		cpu_access(16'h8012, 1'b0, 16'h0000, 2'b00, lat_c);
		sprite_read(16'h8013, lat_s);

		// one requester per bank finishing in the next cycle
		fork
			sprite_read(16'h0200, lat_s);
			bg0_read(16'h4201, lat_b);
			cpu_access(16'h8202, 1'b0, 16'h0000, 2'b00, lat_c);
			flash_write(16'hc300, 16'h0f0f, lat_f);
		join
		check("parallel sprite latency", lat_s, 1);
		check("parallel background latency", lat_b, 1);
		check("parallel cpu latency", lat_c, 1);
		check("parallel flash latency", lat_f, 1);

		// random traffic in a 256 word window where the low two bits name the port
		for (int w = 0; w < 256; w++)
		begin
			a = {2'(w >> 6), 8'h00, 6'(w)};
			flash_write(a, a ^ 16'h3c3c, lat_f);
		end
		for (int r = 0; r < 300; r++)
		begin
			for (int p = 0; p < 4; p++)
			begin
				en[p] = (rand_bits(1) != 0);
				bank = 2'(rand_bits(2));
				word = 4'(rand_bits(4));
				ra[p] = {bank, 8'h00, word, 2'(p)};
			end
			cw = 1'(rand_bits(1));
			cm = 2'(rand_bits(2));
			rd[0] = 16'(rand_bits(16));
			rd[1] = 16'(rand_bits(16));
			fork
				if (en[0]) sprite_read(ra[0], lat_s);
				if (en[1]) bg0_read(ra[1], lat_b);
				if (en[2]) cpu_access(ra[2], cw, rd[0], cm, lat_c);
				if (en[3]) flash_write(ra[3], rd[1], lat_f);
			join
		end

		repeat (4) @(negedge CLK);
		$display("mismatches %0d, timeouts %0d, stray readies %0d", mismatches, timeouts, strays);
		if (mismatches == 0 && timeouts == 0 && strays == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
design/mem_map_pkg.sv
design/mem_port_pkg.sv
design/mem_bank.sv
design/mem_bank_arbiter.sv
design/mem_controller.sv
dv/mem_controller_properties.sv
dv/mem_controller_tb.sv
